// ==== sdram_defines.svh ====
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// geometry
`define SDRAM_ROW_W      13
`define SDRAM_COL_W      8
`define SDRAM_BANKS      4
`define SDRAM_BANK_W     2
`define SDRAM_DATA_W     32
`define SDRAM_ADDR_W     23
`define SDRAM_BURST_LEN  4

// timing in clock cycles, 3-3-3 part
`define SDRAM_T_RCD      3   // ACTIVATE on pins to READ/WRITE
`define SDRAM_T_RP       3   // PRECHARGE on pins to ACTIVATE
`define SDRAM_CAS_LAT    3   // READ on pins to first data word

// {cs, ras, cas, we}
`define SDRAM_CMD_NOP        4'b0111
`define SDRAM_CMD_ACTIVE     4'b0011
`define SDRAM_CMD_READ       4'b0101
`define SDRAM_CMD_WRITE      4'b0100
`define SDRAM_CMD_PRECHARGE  4'b0010

`endif

// ==== sdram_pkg.sv ====
package sdram_pkg;

    // pin order matches the command code bits
    typedef struct packed {
        logic cs;
        logic ras;
        logic cas;
        logic we;
    } sdram_pins_t;

    // one command word, seen as a code or as the four strobe pins
    typedef union packed {
        logic [3:0]  code;
        sdram_pins_t pins;
    } sdram_cmd_u;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACTIVATE,    // ACTIVATE waiting for grant
        ST_WAIT_ACT,
        ST_ACCESS,      // READ or WRITE waiting for grant
        ST_PRECHARGE,
        ST_WAIT_PRE,
        ST_READ_BURST
    } bank_state_e;

endpackage

// ==== sdram_req_decode.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_req_decode (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          in_valid,
    input  logic [`SDRAM_ADDR_W-1:0]                      user_addr,
    input  logic                                          rw,
    input  logic [`SDRAM_DATA_W-1:0]                      data_in,
    input  logic [`SDRAM_BANKS-1:0]                       rsp_valid,
    input  logic [`SDRAM_BANKS-1:0][`SDRAM_DATA_W-1:0]    rsp_data,
    output logic [`SDRAM_BANKS-1:0]                       req,
    output logic [`SDRAM_ROW_W-1:0]                       row,
    output logic [`SDRAM_COL_W-1:0]                       col,
    output logic                                          bank_rw,
    output logic [`SDRAM_DATA_W-1:0]                      wdata,
    output logic [`SDRAM_DATA_W-1:0]                      data_out,
    output logic                                          out_valid
);

    logic [`SDRAM_BANK_W-1:0] bank;
    logic [`SDRAM_DATA_W-1:0] rsp_sel;

    // interleaved map, bit 4 and bit 14 pick the bank so that
    // neighbouring lines land in different banks
    assign row  = {user_addr[22:15], user_addr[13:9]};
    assign bank = {user_addr[14], user_addr[4]};
    assign col  = {user_addr[8:5], user_addr[3:0]};

    assign bank_rw = rw;
    assign wdata   = data_in;

    // one-hot strobe into the addressed bank only
    assign req = in_valid ? (`SDRAM_BANKS'(1) << bank) : '0;

    always_comb begin
        rsp_sel = '0;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            if (rsp_valid[i]) begin
                rsp_sel = rsp_data[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= |rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (|rsp_valid) begin
            data_out <= rsp_sel;   // held until the next response
        end
    end

    // banks never answer in the same cycle while one read is in flight
    assert property (@(posedge clk) disable iff (rst) $onehot0(rsp_valid))
        else $error("more than one bank response at once: %b", rsp_valid);

endmodule

// ==== sdram_bank.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_bank #(
    parameter int bank_id = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [`SDRAM_ROW_W-1:0]  row,
    input  logic [`SDRAM_COL_W-1:0]  col,
    input  logic                     rw,
    input  logic [`SDRAM_DATA_W-1:0] wdata,
    input  logic                     grant,
    input  logic                     rd_word_valid,
    input  logic [`SDRAM_BANK_W-1:0] rd_bank,
    input  logic [`SDRAM_DATA_W-1:0] rd_data,
    input  logic                     rd_last,
    output logic                     busy,
    output logic                     cmd_req,
    output sdram_pkg::sdram_cmd_u    cmd,
    output logic [`SDRAM_ROW_W-1:0]  cmd_addr,
    output logic [`SDRAM_DATA_W-1:0] cmd_wdata,
    output logic                     is_read,
    output logic                     rsp_valid,
    output logic [`SDRAM_DATA_W-1:0] rsp_data
);

    localparam int tag_w = `SDRAM_ROW_W + `SDRAM_COL_W - 4;

    sdram_pkg::bank_state_e  state;
    logic [`SDRAM_ROW_W-1:0] row_q;
    logic [`SDRAM_COL_W-1:0] col_q;
    logic                    rw_q;
    logic                    open_flag;
    logic [`SDRAM_ROW_W-1:0] open_row;
    logic [3:0]              wait_cnt;
    logic                    first;
    logic [1:0]              burst_idx;
    logic                    line_valid;
    logic [tag_w-1:0]        line_tag;
    logic [`SDRAM_DATA_W-1:0] line [`SDRAM_BURST_LEN];
    logic                    hit;
    logic                    take;

    // tag is the row plus the line part of the column
    assign hit  = !rw && line_valid && (line_tag == {row, col[`SDRAM_COL_W-1:4]});
    assign take = (state == sdram_pkg::ST_READ_BURST) && rd_word_valid
                  && (rd_bank == `SDRAM_BANK_W'(bank_id));

    assign cmd_req = state inside {sdram_pkg::ST_ACTIVATE, sdram_pkg::ST_ACCESS,
                                   sdram_pkg::ST_PRECHARGE};
    assign is_read = (state == sdram_pkg::ST_ACCESS) && !rw_q;

    always_comb begin
        cmd.code = `SDRAM_CMD_NOP;
        cmd_addr = '0;   // a10 low, precharge this bank only
        case (state)
            sdram_pkg::ST_ACTIVATE: begin
                cmd.code = `SDRAM_CMD_ACTIVE;
                cmd_addr = row_q;
            end
            sdram_pkg::ST_ACCESS: begin
                cmd.code = rw_q ? `SDRAM_CMD_WRITE : `SDRAM_CMD_READ;
                cmd_addr = `SDRAM_ROW_W'(col_q[`SDRAM_COL_W-1:2]);   // word column
            end
            sdram_pkg::ST_PRECHARGE: cmd.code = `SDRAM_CMD_PRECHARGE;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= sdram_pkg::ST_IDLE;
            busy       <= 1'b0;
            open_flag  <= 1'b0;
            line_valid <= 1'b0;
            rsp_valid  <= 1'b0;
            first      <= 1'b0;
            wait_cnt   <= '0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                sdram_pkg::ST_IDLE: begin
                    if (req && hit) begin
                        rsp_valid <= 1'b1;   // served from the line
                    end else if (req) begin
                        busy <= 1'b1;
                        if (rw) line_valid <= 1'b0;   // line would go stale
                        if (!open_flag) state <= sdram_pkg::ST_ACTIVATE;
                        else if (open_row == row) state <= sdram_pkg::ST_ACCESS;
                        else state <= sdram_pkg::ST_PRECHARGE;
                    end
                end
                sdram_pkg::ST_ACTIVATE: begin
                    if (grant) begin
                        state     <= sdram_pkg::ST_WAIT_ACT;
                        wait_cnt  <= 4'(`SDRAM_T_RCD - 2);   // grant and pin cycles count
                        open_flag <= 1'b1;
                    end
                end
                sdram_pkg::ST_WAIT_ACT: begin
                    if (wait_cnt == '0) state <= sdram_pkg::ST_ACCESS;
                    else wait_cnt <= wait_cnt - 1'b1;
                end
                sdram_pkg::ST_PRECHARGE: begin
                    if (grant) begin
                        state     <= sdram_pkg::ST_WAIT_PRE;
                        wait_cnt  <= 4'(`SDRAM_T_RP - 2);
                        open_flag <= 1'b0;
                    end
                end
                sdram_pkg::ST_WAIT_PRE: begin
                    if (wait_cnt == '0) state <= sdram_pkg::ST_ACTIVATE;
                    else wait_cnt <= wait_cnt - 1'b1;
                end
                sdram_pkg::ST_ACCESS: begin
                    if (grant && rw_q) begin
                        state <= sdram_pkg::ST_IDLE;
                        busy  <= 1'b0;   // write data goes out with the command
                    end else if (grant) begin
                        state <= sdram_pkg::ST_READ_BURST;
                        first <= 1'b1;
                    end
                end
                sdram_pkg::ST_READ_BURST: begin
                    if (take) begin
                        first <= 1'b0;
                        if (first) rsp_valid <= 1'b1;   // requested word comes first
                        if (rd_last) begin
                            state      <= sdram_pkg::ST_IDLE;
                            busy       <= 1'b0;
                            line_valid <= 1'b1;
                        end
                    end
                end
                default: state <= sdram_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sdram_pkg::ST_IDLE && req) begin
            row_q     <= row;
            col_q     <= col;
            rw_q      <= rw;
            cmd_wdata <= wdata;
            rsp_data  <= line[col[3:2]];
        end
        if (state == sdram_pkg::ST_ACTIVATE && grant) open_row <= row_q;
        if (state == sdram_pkg::ST_ACCESS && grant) burst_idx <= col_q[3:2];
        if (take) begin
            line[burst_idx] <= rd_data;
            burst_idx       <= burst_idx + 1'b1;   // wraps within the line
            if (first) rsp_data <= rd_data;
            if (rd_last) line_tag <= {row_q, col_q[`SDRAM_COL_W-1:4]};
        end
    end

    // requester must watch bank_busy before pulsing in_valid
    assert property (@(posedge clk) disable iff (rst) req |-> !busy)
        else $error("request into busy bank %0d", bank_id);

endmodule

// ==== sdram_cmd_issue.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_cmd_issue (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [`SDRAM_BANKS-1:0]                    cmd_req,
    input  sdram_pkg::sdram_cmd_u [`SDRAM_BANKS-1:0]   cmd,
    input  logic [`SDRAM_BANKS-1:0][`SDRAM_ROW_W-1:0]  cmd_addr,
    input  logic [`SDRAM_BANKS-1:0][`SDRAM_DATA_W-1:0] cmd_wdata,
    input  logic [`SDRAM_BANKS-1:0]                    is_read,
    input  logic [`SDRAM_DATA_W-1:0]                   sdram_dqi,
    output logic [`SDRAM_BANKS-1:0]                    grant,
    output logic                                       sdram_cke,
    output logic                                       sdram_cs,
    output logic                                       sdram_ras,
    output logic                                       sdram_cas,
    output logic                                       sdram_we,
    output logic [`SDRAM_DATA_W/8-1:0]                 sdram_dqm,
    output logic [`SDRAM_BANK_W-1:0]                   sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]                    sdram_a,
    output logic [`SDRAM_DATA_W-1:0]                   sdram_dqo,
    output logic                                       sdram_dq_en,
    output logic                                       rd_word_valid,
    output logic [`SDRAM_BANK_W-1:0]                   rd_bank,
    output logic [`SDRAM_DATA_W-1:0]                   rd_data,
    output logic                                       rd_last
);

    localparam int sr_len = `SDRAM_CAS_LAT + `SDRAM_BURST_LEN;
    // word slots of one burst, counted from the READ on the pins
    localparam logic [sr_len-1:0] burst_slots =
        sr_len'({`SDRAM_BURST_LEN{1'b1}}) << `SDRAM_CAS_LAT;

    logic [`SDRAM_BANKS-1:0] elig;
    logic [`SDRAM_BANKS-1:0] mask;
    logic [`SDRAM_BANKS-1:0] m_req;
    logic [`SDRAM_BANKS-1:0] um_pre;
    logic [`SDRAM_BANKS-1:0] m_pre;
    logic [`SDRAM_BANKS-1:0] above;
    logic [`SDRAM_BANK_W-1:0] gnt_idx;
    logic                    bus_busy;
    logic                    rd_go;
    logic                    wr_go;
    logic [sr_len-1:0]       sr_valid;
    logic [sr_len-1:0][`SDRAM_BANK_W-1:0] sr_bank;
    sdram_pkg::sdram_cmd_u   pin_cmd;

    assign bus_busy = |sr_valid;   // a burst still owns dq
    assign m_req    = elig & mask;

    // mask-based round robin, lowest eligible bank above the last grant wins
    always_comb begin
        um_pre = '0;
        m_pre  = '0;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            elig[i] = cmd_req[i] && !(bus_busy
                      && (is_read[i] || cmd[i].code == `SDRAM_CMD_WRITE));
            if (i > 0) begin
                um_pre[i] = um_pre[i-1] | elig[i-1];
                m_pre[i]  = m_pre[i-1] | m_req[i-1];
            end
        end
        grant = (|m_req) ? (m_req & ~m_pre) : (elig & ~um_pre);
    end

    always_comb begin
        above   = '0;
        gnt_idx = '0;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            if (i > 0) above[i] = above[i-1] | grant[i-1];
            if (grant[i]) gnt_idx = `SDRAM_BANK_W'(i);
        end
    end

    assign rd_go = |(grant & is_read);
    assign wr_go = (|grant) && (cmd[gnt_idx].code == `SDRAM_CMD_WRITE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pin_cmd.code  <= `SDRAM_CMD_NOP;
            sdram_cke     <= 1'b0;
            sdram_dq_en   <= 1'b0;
            mask          <= '1;
            sr_valid      <= '0;
            rd_word_valid <= 1'b0;
            rd_last       <= 1'b0;
        end else begin
            sdram_cke <= 1'b1;
            if (|grant) pin_cmd <= cmd[gnt_idx];
            else pin_cmd.code <= `SDRAM_CMD_NOP;
            sdram_dq_en <= wr_go;   // data with the WRITE itself
            if (|grant) mask <= above;
            sr_valid <= rd_go ? ((sr_valid >> 1) | burst_slots) : (sr_valid >> 1);
            rd_word_valid <= sr_valid[0];
            rd_last       <= sr_valid[0] && !sr_valid[1];
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            sdram_ba  <= gnt_idx;
            sdram_a   <= cmd_addr[gnt_idx];
            sdram_dqo <= cmd_wdata[gnt_idx];
        end
        sr_bank <= {`SDRAM_BANK_W'(0), sr_bank[sr_len-1:1]};
        if (rd_go) begin
            for (int k = `SDRAM_CAS_LAT; k < sr_len; k++) sr_bank[k] <= gnt_idx;
        end
        rd_data <= sdram_dqi;   // input register stage
        rd_bank <= sr_bank[0];
    end

    assign sdram_cs  = pin_cmd.pins.cs;
    assign sdram_ras = pin_cmd.pins.ras;
    assign sdram_cas = pin_cmd.pins.cas;
    assign sdram_we  = pin_cmd.pins.we;
    assign sdram_dqm = '0;   // no byte masking

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant not one-hot: %b", grant);

endmodule

// ==== sdram_ctrl.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`SDRAM_ADDR_W-1:0]  user_addr,
    input  logic                      rw,
    input  logic [`SDRAM_DATA_W-1:0]  data_in,
    input  logic                      in_valid,
    input  logic [`SDRAM_DATA_W-1:0]  sdram_dqi,
    output logic [`SDRAM_DATA_W-1:0]  data_out,
    output logic                      out_valid,
    output logic [`SDRAM_BANKS-1:0]   bank_busy,
    output logic                      sdram_cke,
    output logic                      sdram_cs,
    output logic                      sdram_ras,
    output logic                      sdram_cas,
    output logic                      sdram_we,
    output logic [`SDRAM_DATA_W/8-1:0] sdram_dqm,
    output logic [`SDRAM_BANK_W-1:0]  sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]   sdram_a,
    output logic [`SDRAM_DATA_W-1:0]  sdram_dqo,
    output logic                      sdram_dq_en
);

    logic [`SDRAM_BANKS-1:0]                    req;
    logic [`SDRAM_ROW_W-1:0]                    row;
    logic [`SDRAM_COL_W-1:0]                    col;
    logic                                       bank_rw;
    logic [`SDRAM_DATA_W-1:0]                   wdata;
    logic [`SDRAM_BANKS-1:0]                    rsp_valid;
    logic [`SDRAM_BANKS-1:0][`SDRAM_DATA_W-1:0] rsp_data;
    logic [`SDRAM_BANKS-1:0]                    cmd_req;
    sdram_pkg::sdram_cmd_u [`SDRAM_BANKS-1:0]   bank_cmd;
    logic [`SDRAM_BANKS-1:0][`SDRAM_ROW_W-1:0]  cmd_addr;
    logic [`SDRAM_BANKS-1:0][`SDRAM_DATA_W-1:0] cmd_wdata;
    logic [`SDRAM_BANKS-1:0]                    is_read;
    logic [`SDRAM_BANKS-1:0]                    grant;
    logic                                       rd_word_valid;
    logic [`SDRAM_BANK_W-1:0]                   rd_bank;
    logic [`SDRAM_DATA_W-1:0]                   rd_data;
    logic                                       rd_last;

    sdram_req_decode u_decode (
        .clk(clk), .rst(rst), .in_valid(in_valid), .user_addr(user_addr),
        .rw(rw), .data_in(data_in), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
        .req(req), .row(row), .col(col), .bank_rw(bank_rw), .wdata(wdata),
        .data_out(data_out), .out_valid(out_valid)
    );

    for (genvar i = 0; i < `SDRAM_BANKS; i++) begin : g_bank
        sdram_bank #(.bank_id(i)) u_bank (
            .clk(clk), .rst(rst), .req(req[i]), .row(row), .col(col), .rw(bank_rw),
            .wdata(wdata), .grant(grant[i]), .rd_word_valid(rd_word_valid),
            .rd_bank(rd_bank), .rd_data(rd_data), .rd_last(rd_last),
            .busy(bank_busy[i]), .cmd_req(cmd_req[i]), .cmd(bank_cmd[i]),
            .cmd_addr(cmd_addr[i]), .cmd_wdata(cmd_wdata[i]), .is_read(is_read[i]),
            .rsp_valid(rsp_valid[i]), .rsp_data(rsp_data[i])
        );
    end

    sdram_cmd_issue u_issue (
        .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd(bank_cmd), .cmd_addr(cmd_addr),
        .cmd_wdata(cmd_wdata), .is_read(is_read), .sdram_dqi(sdram_dqi), .grant(grant),
        .sdram_cke(sdram_cke), .sdram_cs(sdram_cs), .sdram_ras(sdram_ras),
        .sdram_cas(sdram_cas), .sdram_we(sdram_we), .sdram_dqm(sdram_dqm),
        .sdram_ba(sdram_ba), .sdram_a(sdram_a), .sdram_dqo(sdram_dqo),
        .sdram_dq_en(sdram_dq_en), .rd_word_valid(rd_word_valid), .rd_bank(rd_bank),
        .rd_data(rd_data), .rd_last(rd_last)
    );

endmodule

// ==== tb_sdram_model.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module tb_sdram_model (
    input  logic                     clk,
    input  logic                     cke,
    input  logic                     cs,
    input  logic                     ras,
    input  logic                     cas,
    input  logic                     we,
    input  logic [`SDRAM_BANK_W-1:0] ba,
    input  logic [`SDRAM_ROW_W-1:0]  a,
    input  logic [`SDRAM_DATA_W-1:0] dqo,
    input  logic                     dq_en,
    output logic [`SDRAM_DATA_W-1:0] dqi,
    output logic                     violation
);

    localparam int pipe_len = `SDRAM_CAS_LAT + `SDRAM_BURST_LEN;
    localparam int key_w    = `SDRAM_BANK_W + `SDRAM_ROW_W + 6;   // bank, row, word column

    sdram_pkg::sdram_cmd_u    cmd_now;
    logic [`SDRAM_DATA_W-1:0] store [logic [key_w-1:0]];   // sparse, written words only
    logic [`SDRAM_DATA_W-1:0] pipe [pipe_len];             // words waiting for the dq bus
    logic                     bank_open [`SDRAM_BANKS];
    logic [`SDRAM_ROW_W-1:0]  open_row [`SDRAM_BANKS];
    int                       act_at [`SDRAM_BANKS];
    int                       pre_at [`SDRAM_BANKS];
    int                       cycle = 0;

    always_comb cmd_now.pins = {cs, ras, cas, we};

    // unwritten words carry their own bank, row and column
    function automatic logic [`SDRAM_DATA_W-1:0] word_at(input logic [key_w-1:0] key);
        if (store.exists(key)) return store[key];
        return {11'h5a3, key};
    endfunction

    task automatic violate(input string what);
        $display("SDRAM model: %s, bank %0d at %0t", what, ba, $time);
        violation = 1'b1;
    endtask

    initial begin
        dqi       = '0;
        violation = 1'b0;
        for (int i = 0; i < pipe_len; i++) pipe[i] = '0;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            bank_open[b] = 1'b0;
            act_at[b]    = -100;
            pre_at[b]    = -100;
        end
    end

    always @(posedge clk) begin
        cycle++;
        dqi <= pipe[0];
        for (int i = 0; i < pipe_len - 1; i++) pipe[i] = pipe[i+1];
        pipe[pipe_len-1] = '0;
        if (cke) begin
            case (cmd_now.code)
                `SDRAM_CMD_ACTIVE: begin
                    if (bank_open[ba]) violate("ACTIVATE to an open bank");
                    else if (cycle - pre_at[ba] < `SDRAM_T_RP) violate("tRP gap too short");
                    else begin
                        bank_open[ba] = 1'b1;
                        open_row[ba]  = a;
                        act_at[ba]    = cycle;
                    end
                end
                `SDRAM_CMD_PRECHARGE: begin
                    bank_open[ba] = 1'b0;
                    pre_at[ba]    = cycle;
                end
                `SDRAM_CMD_READ, `SDRAM_CMD_WRITE: begin
                    if (!bank_open[ba]) violate("READ or WRITE to a closed bank");
                    else if (cycle - act_at[ba] < `SDRAM_T_RCD) violate("tRCD gap too short");
                    else if (!cmd_now.pins.we) begin
                        if (!dq_en) violate("WRITE without data on the bus");
                        else store[{ba, open_row[ba], a[5:0]}] = dqo;
                    end else begin
                        // sequential burst wraps inside the aligned group of four
                        for (int k = 0; k < `SDRAM_BURST_LEN; k++) begin
                            pipe[`SDRAM_CAS_LAT-2+k] =
                                word_at({ba, open_row[ba], a[5:2], 2'(a[1:0] + 2'(k))});
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module tb_sdram_ctrl;

    localparam int clk_period = 40;
    localparam int random_ops = 200;
    localparam int total_ops  = random_ops + 8;   // 8 directed accesses first

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       rw;
    logic [`SDRAM_ADDR_W-1:0]   user_addr;
    logic [`SDRAM_DATA_W-1:0]   data_in;
    logic [`SDRAM_DATA_W-1:0]   sdram_dqi;
    logic [`SDRAM_DATA_W-1:0]   data_out;
    logic                       out_valid;
    logic [`SDRAM_BANKS-1:0]    bank_busy;
    logic                       sdram_cke;
    logic                       sdram_cs;
    logic                       sdram_ras;
    logic                       sdram_cas;
    logic                       sdram_we;
    logic [`SDRAM_DATA_W/8-1:0] sdram_dqm;
    logic [`SDRAM_BANK_W-1:0]   sdram_ba;
    logic [`SDRAM_ROW_W-1:0]    sdram_a;
    logic [`SDRAM_DATA_W-1:0]   sdram_dqo;
    logic                       sdram_dq_en;
    logic                       violation;
    sdram_pkg::sdram_cmd_u      pins_now;

    logic [`SDRAM_DATA_W-1:0]   image [logic [`SDRAM_ADDR_W-1:0]];   // every word written
    logic [`SDRAM_DATA_W-1:0]   rd_expect;
    logic                       rd_hit;
    time                        rd_time;
    int                         reads_issued = 0;
    int                         reads_done   = 0;
    int                         read_cmds    = 0;
    int                         pre_cmds     = 0;

    sdram_ctrl uut (.*);

    tb_sdram_model mem (
        .clk(clk), .cke(sdram_cke), .cs(sdram_cs), .ras(sdram_ras), .cas(sdram_cas),
        .we(sdram_we), .ba(sdram_ba), .a(sdram_a), .dqo(sdram_dqo), .dq_en(sdram_dq_en),
        .dqi(sdram_dqi), .violation(violation)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always_comb pins_now.pins = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    always @(posedge clk) begin
        if (pins_now.code == `SDRAM_CMD_READ) read_cmds <= read_cmds + 1;
        if (pins_now.code == `SDRAM_CMD_PRECHARGE) pre_cmds <= pre_cmds + 1;
        check_mask("sdram_dqm", sdram_dqm, '0);   // no byte masking
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // last write wins, else {5a3, bank, row, word column} as the model fills
    function automatic logic [`SDRAM_DATA_W-1:0] expected_word(
        input logic [`SDRAM_ADDR_W-1:0] addr);
        if (image.exists(addr)) return image[addr];
        return {11'h5a3, addr[14], addr[4], addr[22:15], addr[13:9], addr[8:5], addr[3:2]};
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [`SDRAM_DATA_W-1:0] got,
                              input logic [`SDRAM_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_busy(input string name, input logic [`SDRAM_BANKS-1:0] got,
                              input logic [`SDRAM_BANKS-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [`SDRAM_DATA_W/8-1:0] got,
                              input logic [`SDRAM_DATA_W/8-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_free(input logic [`SDRAM_ADDR_W-1:0] addr);
        do @(posedge clk); while (bank_busy[{addr[14], addr[4]}]);   // bank bits 14 and 4
    endtask

    task automatic do_write(input logic [`SDRAM_ADDR_W-1:0] addr,
                            input logic [`SDRAM_DATA_W-1:0] data);
        wait_free(addr);
        image[addr] = data;
        in_valid  <= 1'b1;
        rw        <= 1'b1;
        user_addr <= addr;
        data_in   <= data;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic do_read(input logic [`SDRAM_ADDR_W-1:0] addr, input logic hit);
        int reads_before;
        wait_free(addr);
        reads_before = read_cmds;
        rd_expect    <= expected_word(addr);
        rd_hit       <= hit;
        rd_time      <= $time;
        reads_issued <= reads_issued + 1;
        in_valid     <= 1'b1;
        rw           <= 1'b0;
        user_addr    <= addr;
        @(posedge clk);
        in_valid <= 1'b0;
        while (reads_done != reads_issued) @(posedge clk);
        if (hit) check_count("READ commands on the pins", read_cmds - reads_before, 0);
    endtask

    always @(posedge clk) begin
        if (out_valid) begin
            if (reads_done == reads_issued) begin
                $display("out_valid at %0t while no read was outstanding", $time);
                stop_run();
            end else begin
                check_data("data_out", data_out, rd_expect);
                if (rd_hit) begin
                    check_count("hit latency",
                                int'(($time - rd_time) / clk_period) - 1, 2);
                end
                reads_done <= reads_done + 1;
            end
        end
    end

    always @(posedge violation) begin
        $display("SDRAM model saw a protocol violation");
        stop_run();
    end

    initial begin
        #(total_ops * 40 * clk_period);
        $display("watchdog expired at %0t before the sequence finished", $time);
        stop_run();
    end

    initial begin
        logic [31:0]              seed;
        logic [`SDRAM_ADDR_W-1:0] addr;
        int                       pre_before;
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_bit("sdram_cke", sdram_cke, 1'b0);   // first cycle out of reset
        @(posedge clk);
        check_bit("sdram_cke", sdram_cke, 1'b1);
        check_busy("bank_busy", bank_busy, '0);

        do_read(23'h000000, 1'b0);   // bank 0 row 0, fill word
        do_read(23'h000004, 1'b1);   // same line
        do_write(23'h000010, 32'h1234_5678);   // bank 1, closed
        do_read(23'h000010, 1'b0);
        pre_before = pre_cmds;
        do_read(23'h000200, 1'b0);   // bank 0 row 1, row miss
        check_count("PRECHARGE commands on the pins", pre_cmds - pre_before, 1);
        do_write(23'h000204, 32'hcafe_0001);   // into the cached line
        do_read(23'h000204, 1'b0);
        do_read(23'h000208, 1'b1);

        seed = 32'hf390_09b5;
        for (int n = 0; n < random_ops; n++) begin
            seed = lcg_next(seed);
            addr = seed[31:9] & 23'h00467c;   // 4 banks, 4 rows, 4 lines of 4 words
            if (seed[8]) begin
                seed = lcg_next(seed);
                do_write(addr, seed);
            end else begin
                do_read(addr, 1'b0);
            end
        end
        do @(posedge clk); while (bank_busy != '0);
        repeat (2) @(posedge clk);   // last WRITE still on its way through the pins

        if (violation) begin
            stop_run();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+.
sdram_pkg.sv
sdram_req_decode.sv
sdram_bank.sv
sdram_cmd_issue.sv
sdram_ctrl.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_sdram_ctrl \
    -o tb_sdram_ctrl \
    && ./obj_dir/tb_sdram_ctrl \
    || exit 1
